// File: design/rapid_isa_pkg.sv
package rapid_isa_pkg;

    // data path width
    localparam int unsigned XLEN = 32;
    // byte step between sequential instructions
    localparam int unsigned INSTR_BYTES = 4;
    // addi x0, x0, 0 is the canonical nop
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // alu funct3, add and sub share a code
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLT     = 3'b010,
        F3_XOR     = 3'b100,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_alu_e;

    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001
    } funct3_br_e;

endpackage

// File: design/rapid_ctrl_pkg.sv
package rapid_ctrl_pkg;

    // pc value after reset
    localparam logic [rapid_isa_pkg::XLEN-1:0] RESET_PC = '0;

    // register number, x0 .. x31
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // everything execute needs from decode
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic     imm_sel;
        mem_op_e  mem_op;
        logic     branch;
        logic     branch_ne;
        logic     jump;
    } control_ex_s;

    // what survives into the memory stage
    typedef struct packed {
        reg_idx_t rd;
        mem_op_e  mem_op;
    } control_mem_s;

    // bubble, behaves like addi x0, x0, 0
    localparam control_ex_s CTRL_EX_NOP = '{
        rs1: '0, rs2: '0, rd: '0, alu_op: ALU_ADD, imm_sel: 1'b1,
        mem_op: MEM_NONE, branch: 1'b0, branch_ne: 1'b0, jump: 1'b0
    };

endpackage

// File: design/rapid_stage_if.sv
// decode to execute bundle
// register read data is bound here by the top level
interface de_ex_if;

    logic [rapid_isa_pkg::XLEN-1:0] pc;
    rapid_ctrl_pkg::control_ex_s    control;
    logic [rapid_isa_pkg::XLEN-1:0] rs1_data;
    logic [rapid_isa_pkg::XLEN-1:0] rs2_data;
    logic [rapid_isa_pkg::XLEN-1:0] imm;

    // decoder side
    modport source (
        output pc,
        output control,
        output imm
    );

    // execute side, sampled every edge
    modport sink (
        input pc,
        input control,
        input rs1_data,
        input rs2_data,
        input imm
    );

endinterface

// execute to memory bundle, all combinational
interface ex_mem_if;

    rapid_ctrl_pkg::control_mem_s   control;
    // data address or the rd value
    logic [rapid_isa_pkg::XLEN-1:0] alu_result;
    logic [rapid_isa_pkg::XLEN-1:0] store_data;

    modport source (
        output control,
        output alu_result,
        output store_data
    );

    modport sink (
        input control,
        input alu_result,
        input store_data
    );

endinterface

// File: design/cpu_ifetch_unit.sv
module cpu_ifetch_unit (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // redirect from execute
    input  logic                           i_pc_load,
    input  logic [rapid_isa_pkg::XLEN-1:0] i_pc_ext,
    // also the instruction fetch address
    output logic [rapid_isa_pkg::XLEN-1:0] o_pc
);

    logic [rapid_isa_pkg::XLEN-1:0] pc_next;

    // sequential unless execute resolved a taken branch or jal
    assign pc_next = i_pc_load ? i_pc_ext
                               : o_pc + rapid_isa_pkg::XLEN'(rapid_isa_pkg::INSTR_BYTES);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= rapid_ctrl_pkg::RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

    // redirect targets come from execute, pc must never leave word alignment
    a_pc_aligned : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_pc[1:0] == 2'b00
    ) else $error("fetch pc not word aligned");

endmodule

// File: design/register_file.sv
module register_file (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  rapid_ctrl_pkg::reg_idx_t       i_rs1,
    input  rapid_ctrl_pkg::reg_idx_t       i_rs2,
    // write port, driven by the memory stage
    input  rapid_ctrl_pkg::reg_idx_t       i_rd,
    input  logic [rapid_isa_pkg::XLEN-1:0] i_rd_data,
    output logic [rapid_isa_pkg::XLEN-1:0] o_rs1_data,
    output logic [rapid_isa_pkg::XLEN-1:0] o_rs2_data
);

    logic [rapid_isa_pkg::XLEN-1:0] regs [32];

    // x0 is never written, so it keeps its cleared value
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd != '0) begin
            regs[i_rd] <= i_rd_data;
        end
    end

    // write first, a same-cycle write shows up on the read port
    assign o_rs1_data = (i_rd != '0 && i_rd == i_rs1) ? i_rd_data : regs[i_rs1];
    assign o_rs2_data = (i_rd != '0 && i_rd == i_rs2) ? i_rd_data : regs[i_rs2];

endmodule

// File: design/decoder_module.sv
module decoder_module (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // flush request from execute
    input  logic                           i_pc_load,
    input  logic [rapid_isa_pkg::XLEN-1:0] i_instruction,
    input  logic [rapid_isa_pkg::XLEN-1:0] i_pc,
    de_ex_if.source                        de_ex
);

    logic [rapid_isa_pkg::XLEN-1:0] instr_q;
    logic [rapid_isa_pkg::XLEN-1:0] pc_q;
    rapid_isa_pkg::opcode_e         opcode;
    rapid_ctrl_pkg::control_ex_s    ctrl;
    logic [rapid_isa_pkg::XLEN-1:0] imm;
    logic                           known_op;

    // funct3 to alu op, sub only for register-register ops
    function automatic rapid_ctrl_pkg::alu_op_e alu_sel(logic [2:0] f3, logic sub);
        case (rapid_isa_pkg::funct3_alu_e'(f3))
            rapid_isa_pkg::F3_ADD_SUB: alu_sel = sub ? rapid_ctrl_pkg::ALU_SUB
                                                     : rapid_ctrl_pkg::ALU_ADD;
            rapid_isa_pkg::F3_SLT:     alu_sel = rapid_ctrl_pkg::ALU_SLT;
            rapid_isa_pkg::F3_XOR:     alu_sel = rapid_ctrl_pkg::ALU_XOR;
            rapid_isa_pkg::F3_OR:      alu_sel = rapid_ctrl_pkg::ALU_OR;
            rapid_isa_pkg::F3_AND:     alu_sel = rapid_ctrl_pkg::ALU_AND;
            default:                   alu_sel = rapid_ctrl_pkg::ALU_ADD;
        endcase
    endfunction

    //////////////////////////////
    // instruction register
    //////////////////////////////
    // wrong-path fetch is replaced by a nop on redirect
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            instr_q <= rapid_isa_pkg::NOP_INSTR;
        end else begin
            instr_q <= i_pc_load ? rapid_isa_pkg::NOP_INSTR : i_instruction;
        end
    end

    always_ff @(posedge i_clk) begin
        pc_q <= i_pc;
    end

    //////////////////////////////
    // field decode
    //////////////////////////////
    assign opcode = rapid_isa_pkg::opcode_e'(instr_q[6:0]);

    always_comb begin
        ctrl     = rapid_ctrl_pkg::CTRL_EX_NOP;
        imm      = '0;
        known_op = 1'b1;
        // read ports always follow the rs fields, unused reads are harmless
        ctrl.rs1 = instr_q[19:15];
        ctrl.rs2 = instr_q[24:20];
        case (opcode)
            rapid_isa_pkg::OP: begin
                ctrl.rd      = instr_q[11:7];
                ctrl.imm_sel = 1'b0;
                // bit 30 of funct7 selects sub
                ctrl.alu_op  = alu_sel(instr_q[14:12], instr_q[30]);
            end
            rapid_isa_pkg::OP_IMM: begin
                ctrl.rd     = instr_q[11:7];
                ctrl.alu_op = alu_sel(instr_q[14:12], 1'b0);
                imm         = {{20{instr_q[31]}}, instr_q[31:20]};
            end
            rapid_isa_pkg::LUI: begin
                ctrl.rd     = instr_q[11:7];
                ctrl.alu_op = rapid_ctrl_pkg::ALU_PASS_B;
                imm         = {instr_q[31:12], 12'b0};
            end
            rapid_isa_pkg::LOAD: begin
                ctrl.rd     = instr_q[11:7];
                ctrl.mem_op = rapid_ctrl_pkg::MEM_LOAD;
                imm         = {{20{instr_q[31]}}, instr_q[31:20]};
            end
            rapid_isa_pkg::STORE: begin
                ctrl.mem_op = rapid_ctrl_pkg::MEM_STORE;
                imm         = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
            end
            rapid_isa_pkg::BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = rapid_isa_pkg::funct3_br_e'(instr_q[14:12])
                                 == rapid_isa_pkg::F3_BNE;
                imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                       instr_q[30:25], instr_q[11:8], 1'b0};
            end
            rapid_isa_pkg::JAL: begin
                ctrl.rd   = instr_q[11:7];
                ctrl.jump = 1'b1;
                imm = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                       instr_q[20], instr_q[30:21], 1'b0};
            end
            default: begin
                // anything else becomes a bubble
                ctrl     = rapid_ctrl_pkg::CTRL_EX_NOP;
                known_op = 1'b0;
            end
        endcase
    end

    assign de_ex.pc      = pc_q;
    assign de_ex.control = ctrl;
    assign de_ex.imm     = imm;

    // instruction memory must only hold the supported subset
    a_known_opcode : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) known_op
    ) else $error("unsupported opcode %b decoded as nop", instr_q[6:0]);

endmodule

// File: design/execute_stage.sv
module execute_stage (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    de_ex_if.sink                          de_ex,
    // write-back value one instruction ahead
    input  rapid_ctrl_pkg::reg_idx_t       i_mem_rd,
    input  logic [rapid_isa_pkg::XLEN-1:0] i_mem_rd_data,
    output logic                           o_pc_load,
    output logic [rapid_isa_pkg::XLEN-1:0] o_pc_ext,
    ex_mem_if.source                       ex_mem
);

    rapid_ctrl_pkg::control_ex_s    ctrl_q;
    logic [rapid_isa_pkg::XLEN-1:0] pc_q;
    logic [rapid_isa_pkg::XLEN-1:0] rs1_q;
    logic [rapid_isa_pkg::XLEN-1:0] rs2_q;
    logic [rapid_isa_pkg::XLEN-1:0] imm_q;
    logic [rapid_isa_pkg::XLEN-1:0] fwd_rs1;
    logic [rapid_isa_pkg::XLEN-1:0] fwd_rs2;
    logic [rapid_isa_pkg::XLEN-1:0] op_b;
    logic [rapid_isa_pkg::XLEN-1:0] alu_out;
    logic                           branch_taken;

    //////////////////////////////
    // operand register
    //////////////////////////////
    // a taken redirect squashes the instruction coming from decode
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctrl_q <= rapid_ctrl_pkg::CTRL_EX_NOP;
        end else begin
            ctrl_q <= o_pc_load ? rapid_ctrl_pkg::CTRL_EX_NOP : de_ex.control;
        end
    end

    always_ff @(posedge i_clk) begin
        pc_q  <= de_ex.pc;
        rs1_q <= de_ex.rs1_data;
        rs2_q <= de_ex.rs2_data;
        imm_q <= de_ex.imm;
    end

    // memory stage result wins over the register read unless rd is x0
    assign fwd_rs1 = (i_mem_rd != '0 && i_mem_rd == ctrl_q.rs1) ? i_mem_rd_data : rs1_q;
    assign fwd_rs2 = (i_mem_rd != '0 && i_mem_rd == ctrl_q.rs2) ? i_mem_rd_data : rs2_q;
    assign op_b    = ctrl_q.imm_sel ? imm_q : fwd_rs2;

    //////////////////////////////
    // alu
    //////////////////////////////
    always_comb begin
        case (ctrl_q.alu_op)
            rapid_ctrl_pkg::ALU_SUB:    alu_out = fwd_rs1 - op_b;
            rapid_ctrl_pkg::ALU_AND:    alu_out = fwd_rs1 & op_b;
            rapid_ctrl_pkg::ALU_OR:     alu_out = fwd_rs1 | op_b;
            rapid_ctrl_pkg::ALU_XOR:    alu_out = fwd_rs1 ^ op_b;
            rapid_ctrl_pkg::ALU_SLT:    alu_out = {{(rapid_isa_pkg::XLEN-1){1'b0}},
                                                   $signed(fwd_rs1) < $signed(op_b)};
            rapid_ctrl_pkg::ALU_PASS_B: alu_out = op_b;
            default:                    alu_out = fwd_rs1 + op_b;
        endcase
    end

    // beq and bne both reduce to an equality test
    assign branch_taken = ctrl_q.branch & ((fwd_rs1 == fwd_rs2) ^ ctrl_q.branch_ne);
    assign o_pc_load    = branch_taken | ctrl_q.jump;
    assign o_pc_ext     = pc_q + imm_q;

    // jal writes the link address
    assign ex_mem.alu_result = ctrl_q.jump
                             ? pc_q + rapid_isa_pkg::XLEN'(rapid_isa_pkg::INSTR_BYTES)
                             : alu_out;
    assign ex_mem.store_data = fwd_rs2;
    assign ex_mem.control    = '{rd: ctrl_q.rd, mem_op: ctrl_q.mem_op};

endmodule

// File: design/cpu_memory_unit.sv
module cpu_memory_unit (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    ex_mem_if.sink                         ex_mem,
    // data bus answered in the same cycle
    output logic [rapid_isa_pkg::XLEN-1:0] o_mmu_address,
    input  logic [rapid_isa_pkg::XLEN-1:0] i_mmu_input_data,
    output logic [rapid_isa_pkg::XLEN-1:0] o_mmu_output_data,
    output logic [3:0]                     o_mmu_we,
    // write-back to register file and forwarding
    output rapid_ctrl_pkg::reg_idx_t       o_rd,
    output logic [rapid_isa_pkg::XLEN-1:0] o_rd_data
);

    logic is_store;
    logic is_load;

    assign is_store = ex_mem.control.mem_op == rapid_ctrl_pkg::MEM_STORE;
    assign is_load  = ex_mem.control.mem_op == rapid_ctrl_pkg::MEM_LOAD;

    assign o_mmu_address     = ex_mem.alu_result;
    assign o_mmu_output_data = ex_mem.store_data;
    // word stores only
    assign o_mmu_we          = is_store ? 4'hF : 4'h0;

    // stores write no register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd <= '0;
        end else begin
            o_rd <= is_store ? '0 : ex_mem.control.rd;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rd_data <= is_load ? i_mmu_input_data : ex_mem.alu_result;
    end

    // full word enables only, and a word store needs a word aligned address
    a_word_we : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
            o_mmu_we == 4'h0 || (o_mmu_we == 4'hF && o_mmu_address[1:0] == 2'b00)
    ) else $error("partial byte enable or misaligned store on data bus");

endmodule

// File: design/rapid_x_cpu.sv
module rapid_x_cpu (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // instruction memory
    input  logic [rapid_isa_pkg::XLEN-1:0] i_instruction_fetch_data,
    output logic [rapid_isa_pkg::XLEN-1:0] o_instruction_fetch_address,
    // data memory
    output logic [rapid_isa_pkg::XLEN-1:0] o_mmu_address,
    input  logic [rapid_isa_pkg::XLEN-1:0] i_mmu_input_data,
    output logic [rapid_isa_pkg::XLEN-1:0] o_mmu_output_data,
    output logic [3:0]                     o_mmu_we
);

    // redirect from execute to fetch and decode
    logic                           pc_load;
    logic [rapid_isa_pkg::XLEN-1:0] pc_ext;
    // write-back from memory stage
    rapid_ctrl_pkg::reg_idx_t       mem_rd;
    logic [rapid_isa_pkg::XLEN-1:0] mem_rd_data;

    de_ex_if  de_ex ();
    ex_mem_if ex_mem ();

    //////////////////////////////
    // fetch and decode
    //////////////////////////////
    cpu_ifetch_unit ifetch_unit (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_pc_load (pc_load),
        .i_pc_ext  (pc_ext),
        .o_pc      (o_instruction_fetch_address)
    );

    // read ports follow the decoded rs fields
    register_file reg_file (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (de_ex.control.rs1),
        .i_rs2      (de_ex.control.rs2),
        .i_rd       (mem_rd),
        .i_rd_data  (mem_rd_data),
        .o_rs1_data (de_ex.rs1_data),
        .o_rs2_data (de_ex.rs2_data)
    );

    decoder_module de_stage (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pc_load     (pc_load),
        .i_instruction (i_instruction_fetch_data),
        .i_pc          (o_instruction_fetch_address),
        .de_ex         (de_ex.source)
    );

    //////////////////////////////
    // execute and memory
    //////////////////////////////
    execute_stage ex_stage (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .de_ex         (de_ex.sink),
        .i_mem_rd      (mem_rd),
        .i_mem_rd_data (mem_rd_data),
        .o_pc_load     (pc_load),
        .o_pc_ext      (pc_ext),
        .ex_mem        (ex_mem.source)
    );

    cpu_memory_unit memory_unit (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .ex_mem            (ex_mem.sink),
        .o_mmu_address     (o_mmu_address),
        .i_mmu_input_data  (i_mmu_input_data),
        .o_mmu_output_data (o_mmu_output_data),
        .o_mmu_we          (o_mmu_we),
        .o_rd              (mem_rd),
        .o_rd_data         (mem_rd_data)
    );

endmodule

// File: bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

//////////////////////////////
// instruction encoders
//////////////////////////////
function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rapid_isa_pkg::OP};
endfunction

function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
endfunction

// word store only
function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rapid_isa_pkg::STORE};
endfunction

function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rapid_isa_pkg::BRANCH};
endfunction

function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, rapid_isa_pkg::LUI};
endfunction

function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rapid_isa_pkg::JAL};
endfunction

// initial data ram word, mixes every address bit
function automatic logic [31:0] ram_fill(logic [7:0] idx);
    return ({24'h0, idx} * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
endfunction

//////////////////////////////
// random program
//////////////////////////////
function automatic int random_below(int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// x1 .. x31
function automatic logic [4:0] pick_reg();
    return 5'(1 + random_below(31));
endfunction

function automatic logic [11:0] pick_imm();
    return 12'($random(seed));
endfunction

// word aligned, below the sentinel word
function automatic logic [11:0] pick_addr();
    return 12'(4 * random_below(255));
endfunction

function automatic void emit(logic [31:0] word);
    rom[8'(prog_len)] = word;
    prog_len++;
endfunction

function automatic void build_program();
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm1;
    logic [11:0] imm2;
    logic [11:0] addr;
    for (int blk = 0; blk < 20; blk++) begin
        ra = pick_reg();
        rb = pick_reg();
        rc = pick_reg();
        f7 = 7'b0000000;
        case (random_below(5))
            0: begin
                // reg-reg op on results at distance one and two
                case (random_below(6))
                    0: f3 = 3'b000;
                    1: begin
                        f3 = 3'b000;
                        f7 = 7'b0100000;
                    end
                    2: f3 = 3'b111;
                    3: f3 = 3'b110;
                    4: f3 = 3'b100;
                    default: f3 = 3'b010;
                endcase
                emit(i_type(pick_imm(), 5'd0, 3'b000, ra, rapid_isa_pkg::OP_IMM));
                emit(i_type(pick_imm(), ra, 3'b000, rb, rapid_isa_pkg::OP_IMM));
                emit(r_type(f7, rb, ra, f3, rc));
                emit(s_type(pick_addr(), rc, 5'd0));
            end
            1: begin
                // lui then an immediate op on it
                case (random_below(4))
                    0: f3 = 3'b000;
                    1: f3 = 3'b111;
                    2: f3 = 3'b110;
                    default: f3 = 3'b100;
                endcase
                emit(u_type(20'($random(seed)), ra));
                emit(i_type(pick_imm(), ra, f3, rb, rapid_isa_pkg::OP_IMM));
                emit(s_type(pick_addr(), ra, 5'd0));
                emit(s_type(pick_addr(), rb, 5'd0));
            end
            2: begin
                // store, load back, use at once
                addr = pick_addr();
                emit(s_type(addr, rc, 5'd0));
                emit(i_type(addr, 5'd0, 3'b010, ra, rapid_isa_pkg::LOAD));
                emit(r_type(7'b0000000, ra, ra, 3'b000, rb));
                emit(s_type(pick_addr(), rb, 5'd0));
                // load of a word that may still hold its fill value
                emit(i_type(pick_addr(), 5'd0, 3'b010, rc, rapid_isa_pkg::LOAD));
                emit(s_type(pick_addr(), rc, 5'd0));
            end
            3: begin
                // beq or bne over two stores, equal operands half the time
                imm1 = pick_imm();
                imm2 = random_below(2) != 0 ? imm1 : pick_imm();
                emit(i_type(imm1, 5'd0, 3'b000, ra, rapid_isa_pkg::OP_IMM));
                emit(i_type(imm2, 5'd0, 3'b000, rb, rapid_isa_pkg::OP_IMM));
                emit(b_type(13'd12, rb, ra, 3'(random_below(2))));
                emit(s_type(pick_addr(), ra, 5'd0));
                emit(s_type(pick_addr(), rb, 5'd0));
            end
            default: begin
                // jal over two stores, then store the link
                emit(j_type(21'd12, rc));
                emit(s_type(pick_addr(), ra, 5'd0));
                emit(s_type(pick_addr(), rb, 5'd0));
                emit(s_type(pick_addr(), rc, 5'd0));
            end
        endcase
    end
    emit(s_type(SENTINEL_ADDR[11:0], pick_reg(), 5'd0));
    // park on a jump to itself
    emit(j_type(21'd0, 5'd0));
endfunction

//////////////////////////////
// isa reference model
//////////////////////////////
function automatic logic [31:0] isa_alu(logic [2:0] f3, logic sub, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// runs the program in rom until the sentinel store, fills the expected store list
function automatic int run_reference();
    logic [31:0] x [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic        wr;
    logic        done;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        x[5'(i)] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        mem[8'(i)] = ram_fill(8'(i));
    end
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 4000) begin
        w       = rom[pc[9:2]];
        a       = x[w[19:15]];
        b       = x[w[24:20]];
        next_pc = pc + 32'd4;
        wr      = 1'b1;
        res     = '0;
        case (w[6:0])
            7'b0110011: res = isa_alu(w[14:12], w[30], a, b);
            7'b0010011: res = isa_alu(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
            7'b0110111: res = {w[31:12], 12'b0};
            7'b0000011: begin
                addr = a + {{20{w[31]}}, w[31:20]};
                res  = mem[addr[9:2]];
            end
            7'b0100011: begin
                wr   = 1'b0;
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                mem[addr[9:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
                done = (addr == SENTINEL_ADDR);
            end
            7'b1100011: begin
                wr = 1'b0;
                // funct3 bit 0 set means bne
                if ((a == b) != w[12]) begin
                    next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                res     = pc + 32'd4;
                next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            x[w[11:7]] = res;
        end
        pc = next_pc;
        steps++;
    end
    return exp_addr.size();
endfunction

`endif

// File: bench/rapid_x_cpu_tb.sv
module rapid_x_cpu_tb;

    // last store of the program goes here
    localparam logic [31:0] SENTINEL_ADDR  = 32'h0000_03FC;
    localparam int          TIMEOUT_CYCLES = 5000;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] fetch_addr;
    logic [31:0] instr_data;
    logic [31:0] mmu_addr;
    logic [31:0] mmu_rdata;
    logic [31:0] mmu_wdata;
    logic [3:0]  mmu_we;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    // expected stores in program order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    integer      seed = 9319;
    int          prog_len = 0;
    int          n_exp = 0;
    int          run_errors = 0;
    // owned by the compare process
    int          seen = 0;
    int          check_errors = 0;
    int          out_cycles = 0;
    logic        sentinel_seen = 1'b0;

    `include "tb_program.svh"

    rapid_x_cpu rapid_x_cpu_inst (
        .i_clk                       (clk),
        .i_rst_n                     (rst_n),
        .i_instruction_fetch_data    (instr_data),
        .o_instruction_fetch_address (fetch_addr),
        .o_mmu_address               (mmu_addr),
        .i_mmu_input_data            (mmu_rdata),
        .o_mmu_output_data           (mmu_wdata),
        .o_mmu_we                    (mmu_we)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // memory models
    //////////////////////////////
    assign instr_data = rom[fetch_addr[9:2]];
    assign mmu_rdata  = ram[mmu_addr[9:2]];

    // ram is refilled while reset is held
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                ram[8'(i)] <= ram_fill(8'(i));
            end
        end else if (mmu_we == 4'hF) begin
            ram[mmu_addr[9:2]] <= mmu_wdata;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("MISMATCH at time %0t: %s got %h expected %h", $time, what, got,
                     expected);
            check_errors++;
        end
    endtask

    //////////////////////////////
    // compare process
    //////////////////////////////
    // bus values are settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value({28'h0, mmu_we}, 32'h0, "write enable during reset");
            check_value(fetch_addr, 32'h0, "fetch address during reset");
        end else begin
            out_cycles++;
            if (out_cycles == 1) begin
                check_value(fetch_addr, 32'h0, "first fetch address");
            end
            if (mmu_we != 4'h0) begin
                if (seen >= exp_addr.size()) begin
                    $display("unexpected store beyond the reference list at time %0t, address %h",
                             $time, mmu_addr);
                    check_errors++;
                end else begin
                    check_value(mmu_addr, exp_addr[seen], "store address");
                    check_value(mmu_wdata, exp_data[seen], "store data");
                end
                if (mmu_addr == SENTINEL_ADDR) begin
                    sentinel_seen = 1'b1;
                end
                seen++;
            end
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int cycles;
        // rom fill is addi x0, x0 with the word index
        for (int i = 0; i < 256; i++) begin
            rom[8'(i)] = i_type(12'(i), 5'd0, 3'b000, 5'd0, rapid_isa_pkg::OP_IMM);
        end
        build_program();
        n_exp = run_reference();
        $display("program of %0d words, %0d stores expected", prog_len, n_exp);

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;

        cycles = 0;
        while (!sentinel_seen && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!sentinel_seen) begin
            $display("timeout: no store to the sentinel address within %0d cycles",
                     TIMEOUT_CYCLES);
            run_errors++;
        end

        // let any stray store past the sentinel show up
        cycles = 0;
        while (cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (seen != n_exp) begin
            $display("store count %0d differs from the reference count %0d", seen, n_exp);
            run_errors++;
        end

        $display("check errors: %0d, run errors: %0d, stores seen: %0d of %0d",
                 check_errors, run_errors, seen, n_exp);
        if (check_errors + run_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+bench
design/rapid_isa_pkg.sv
design/rapid_ctrl_pkg.sv
design/rapid_stage_if.sv
design/cpu_ifetch_unit.sv
design/register_file.sv
design/decoder_module.sv
design/execute_stage.sv
design/cpu_memory_unit.sv
design/rapid_x_cpu.sv
bench/rapid_x_cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rapid_x_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rapid_x_cpu_tb -f project.f -o sim_rapid_x_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rapid_x_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0
